// File: vlog.f
+incdir+verilog
verilog/dbg_pkg.sv
verilog/dbg_crc32.sv
verilog/dbg_status_reg.sv
verilog/dbg_spr_biu.sv
verilog/dbg_burst_ctrl.sv
verilog/dbg_cpu_module.sv
sim/tb_dbg_cpu_module.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
TOP       := tb_dbg_cpu_module
FLIST     := vlog.f
OBJ_DIR   := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: sim/tb_dbg_cpu_module.sv
`timescale 1ns/10ps
`include "dbg_macros.svh"

module tb_dbg_cpu_module;

  typedef logic bitq_t[$];

  localparam int SHIFT_BITS = 1000;                      // TAP cycles over all tests, rounded up
  localparam int TIMEOUT_NS = SHIFT_BITS * 4 * 20 + 10000;

  logic                     tck_i;
  logic                     rst_i;
  logic                     capture_dr_i;
  logic                     shift_dr_i;
  logic                     update_dr_i;
  logic                     module_select_i;
  logic                     tdi_i;
  logic [`DBG_DR_WIDTH-1:0] dr;             // TAP data register model
  logic                     module_tdo_o;
  logic                     top_inhibit_o;
  dbg_pkg::word_t           cpu_addr_o;
  dbg_pkg::word_t           cpu_data_o;
  dbg_pkg::word_t           cpu_data_i;
  logic                     cpu_stb_o;
  logic                     cpu_we_o;
  logic                     cpu_ack_i;
  logic                     cpu_bp_i;
  logic                     cpu_stall_o;
  logic                     cpu_rst_o;

  integer         seed;
  dbg_pkg::word_t mem [256];       // SPR space
  dbg_pkg::word_t wr_addr_q[$];    // Writes seen on the bus
  dbg_pkg::word_t wr_data_q[$];
  logic [31:0]    got_q[$];        // Pending compares
  logic [31:0]    exp_q[$];
  string          msg_q[$];
  logic [31:0]    cmp_got;
  logic [31:0]    cmp_exp;
  string          cmp_msg;

  dbg_cpu_module i_dbg_cpu_module (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .tdi_i           (tdi_i),
    .data_register_i (dr),
    .module_tdo_o    (module_tdo_o),
    .top_inhibit_o   (top_inhibit_o),
    .cpu_addr_o      (cpu_addr_o),
    .cpu_data_o      (cpu_data_o),
    .cpu_data_i      (cpu_data_i),
    .cpu_stb_o       (cpu_stb_o),
    .cpu_we_o        (cpu_we_o),
    .cpu_ack_i       (cpu_ack_i),
    .cpu_bp_i        (cpu_bp_i),
    .cpu_stall_o     (cpu_stall_o),
    .cpu_rst_o       (cpu_rst_o)
  );

  always #10 tck_i = ~tck_i;  // 20 ns period

  // TAP shifts LSB out with TDI entering at the top
  always @(posedge tck_i) begin
    if (shift_dr_i)        dr <= {tdi_i, dr[`DBG_DR_WIDTH-1:1]};
    else if (capture_dr_i) dr <= '0;  // Keeps the write start bit clear
  end

  ////////////////////////////////////////
  // SPR memory with an ack after 0 to 3 cycles
  ////////////////////////////////////////

  always begin
    @(posedge tck_i);
    #1;
    if (cpu_stb_o && !cpu_ack_i) begin
      repeat ({$random(seed)} % 4) @(posedge tck_i);
      #1;
      if (cpu_we_o) begin
        mem[cpu_addr_o[7:0]] = cpu_data_o;
        wr_addr_q.push_back(cpu_addr_o);
        wr_data_q.push_back(cpu_data_o);
      end
      cpu_data_i = mem[cpu_addr_o[7:0]];
      cpu_ack_i  = 1'b1;
      @(posedge tck_i);
      #1 cpu_ack_i = 1'b0;
    end
  end

  // Queued checks drain at the falling edge
  always @(negedge tck_i) begin
    while (got_q.size() > 0) begin
      cmp_got = got_q.pop_front();
      cmp_exp = exp_q.pop_front();
      cmp_msg = msg_q.pop_front();
      assert (cmp_got == cmp_exp) else begin
        $display("mismatch at %0t ns: %s, got %h, expected %h", $time, cmp_msg, cmp_got, cmp_exp);
        $display("TESTBENCH FAILED");
        $fatal(1, "compare failed");
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog");
  end

  ////////////////////////////////////////
  // Reference and host tasks
  ////////////////////////////////////////

  // Reflected CRC-32 fed LSB first with no final inversion
  function automatic logic [31:0] crc32_ref(input bitq_t bits);
    logic [31:0] c;
    c = `DBG_CRC_INIT;
    foreach (bits[i]) begin
      if (c[0] ^ bits[i]) c = (c >> 1) ^ `DBG_CRC_POLY;
      else                c = c >> 1;
    end
    return c;
  endfunction

  function automatic logic [52:0] make_cmd(input logic [3:0] op, input logic [31:0] addr,
                                          input logic [15:0] cnt);
    logic [52:0] c;
    c = '0;  // Top bit low selects this module
    c[`DBG_OP_HI:`DBG_OP_LO]     = op;
    c[`DBG_ADDR_HI:`DBG_ADDR_LO] = addr;
    c[`DBG_CNT_HI:`DBG_CNT_LO]   = cnt;
    return c;
  endfunction

  task automatic expect_val(input logic [31:0] got, input logic [31:0] exp, input string msg);
    got_q.push_back(got);
    exp_q.push_back(exp);
    msg_q.push_back(msg);
  endtask

  // One TCK with inputs set 1 ns after the edge and TDO taken at the falling edge
  task automatic tap_cycle(input logic cap, input logic sh, input logic upd, input logic bit_in,
                           output logic tdo);
    capture_dr_i = cap;
    shift_dr_i   = sh;
    update_dr_i  = upd;
    tdi_i        = bit_in;
    @(negedge tck_i);
    tdo = module_tdo_o;
    @(posedge tck_i);
    #1;
  endtask

  task automatic idle(input int n);
    logic tdo;
    repeat (n) tap_cycle(1'b0, 1'b0, 1'b0, 1'b0, tdo);
  endtask

  task automatic send_command(input logic [52:0] cmd);
    logic tdo;
    for (int i = 0; i < `DBG_DR_WIDTH; i++) tap_cycle(1'b0, 1'b1, 1'b0, cmd[i], tdo);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);  // Update
  endtask

  task automatic write_status(input logic [1:0] s);
    logic [52:0] c;
    c = make_cmd(`DBG_CMD_IREG_WR, 32'h0, 16'h0);
    c[`DBG_SREG_HI:`DBG_SREG_LO] = s;
    send_command(c);
    expect_val(32'(cpu_stall_o), 32'(s[0]), "stall after status write");
    expect_val(32'(cpu_rst_o), 32'(s[1]), "reset after status write");
  endtask

  task automatic read_status(input logic [1:0] exp);
    logic       tdo;
    logic [1:0] s;
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);  // Capture
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, s[0]);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, s[1]);
    idle(1);
    expect_val(32'(s), 32'(exp), "status read-back");
  endtask

  task automatic burst_write(input logic [31:0] addr, input logic flip);
    logic        tdo;
    logic [31:0] words [4];
    logic [31:0] crc;
    bitq_t       bits;
    foreach (words[i]) words[i] = $random(seed);
    wr_addr_q.delete();
    wr_data_q.delete();
    send_command(make_cmd(`DBG_CMD_BWRITE32, addr, 16'd4));
    idle(1);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b1, tdo);  // Start bit
    for (int w = 0; w < 4; w++) begin
      for (int b = 0; b < 32; b++) begin
        bits.push_back(words[w][b]);
        tap_cycle(1'b0, 1'b1, 1'b0, words[w][b], tdo);
        expect_val(32'(top_inhibit_o), 32'd1, "inhibit during write");
      end
    end
    crc = crc32_ref(bits);
    if (flip) crc[5] = ~crc[5];  // Corrupt one CRC bit
    for (int b = 0; b < 32; b++) tap_cycle(1'b0, 1'b1, 1'b0, crc[b], tdo);
    tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);  // Match bit
    expect_val(32'(tdo), 32'(!flip), "CRC match bit");
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
    idle(4);
    expect_val(wr_addr_q.size(), 32'd4, "number of SPR writes");
    if (wr_addr_q.size() == 4) begin
      for (int i = 0; i < 4; i++) begin
        expect_val(wr_addr_q[i], addr + 32'(i), "write address");
        expect_val(wr_data_q[i], words[i], "write data");
      end
    end
  endtask

  task automatic burst_read(input logic [31:0] addr, input int n);
    logic        tdo;
    logic [31:0] word;
    logic [31:0] crc;
    bitq_t       bits;
    int          wait_cnt;
    send_command(make_cmd(`DBG_CMD_BREAD32, addr, 16'(n)));
    idle(1);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    tdo      = 1'b0;
    wait_cnt = 0;
    while (!tdo && wait_cnt < 40) begin  // Ready bit
      tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
      wait_cnt++;
    end
    expect_val(32'(tdo), 32'd1, "read start bit");
    for (int w = 0; w < n; w++) begin
      for (int b = 0; b < 32; b++) begin
        tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, word[b]);
        bits.push_back(word[b]);
        expect_val(32'(top_inhibit_o), 32'd1, "inhibit during read");
      end
      expect_val(word, mem[8'(addr + 32'(w))], "read data word");
    end
    for (int b = 0; b < 32; b++) tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, crc[b]);
    expect_val(crc, crc32_ref(bits), "read CRC");
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
    idle(2);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    logic tdo;
    seed            = 32'h6825;
    tck_i           = 1'b0;
    rst_i           = 1'b1;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b0;
    tdi_i           = 1'b0;
    dr              <= '0;
    cpu_data_i      = '0;
    cpu_ack_i       = 1'b0;
    cpu_bp_i        = 1'b0;
    for (int i = 0; i < 256; i++) mem[i] = {8'(i) ^ 8'h5a, 8'(i), ~8'(i), 8'(i) + 8'h33};
    repeat (2) @(posedge tck_i);
    #1 rst_i = 1'b0;
    module_select_i = 1'b1;

    expect_val(32'({module_tdo_o, cpu_stb_o, cpu_we_o, cpu_stall_o, cpu_rst_o, top_inhibit_o}),
               32'd0, "outputs after reset");

    write_status(2'b01);
    read_status(2'b01);
    write_status(2'b00);
    cpu_bp_i = 1'b1;  // Breakpoint pulse
    idle(1);
    cpu_bp_i = 1'b0;
    expect_val(32'(cpu_stall_o), 32'd1, "stall after breakpoint");
    read_status(2'b01);

    burst_write(32'h10, 1'b0);
    burst_write(32'h20, 1'b1);
    burst_read(32'h40, 3);

    // Read cut short by update
    send_command(make_cmd(`DBG_CMD_BREAD32, 32'h80, 16'd3));
    idle(1);
    tap_cycle(1'b1, 1'b0, 1'b0, 1'b0, tdo);
    repeat (20) tap_cycle(1'b0, 1'b1, 1'b0, 1'b0, tdo);
    tap_cycle(1'b0, 1'b0, 1'b1, 1'b0, tdo);
    idle(6);
    expect_val(32'(top_inhibit_o), 32'd0, "inhibit after early update");
    read_status(2'b01);

    idle(2);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: verilog/dbg_cpu_module.sv
`timescale 1ns/10ps
`include "dbg_macros.svh"

module dbg_cpu_module (
  input  logic                     tck_i,
  input  logic                     rst_i,
  // TAP
  input  logic                     capture_dr_i,
  input  logic                     shift_dr_i,
  input  logic                     update_dr_i,
  input  logic                     module_select_i,
  input  logic                     tdi_i,
  input  logic [`DBG_DR_WIDTH-1:0] data_register_i,
  output logic                     module_tdo_o,
  output logic                     top_inhibit_o,
  // SPR bus
  output dbg_pkg::word_t           cpu_addr_o,
  output dbg_pkg::word_t           cpu_data_o,
  input  dbg_pkg::word_t           cpu_data_i,
  output logic                     cpu_stb_o,
  output logic                     cpu_we_o,
  input  logic                     cpu_ack_i,
  // CPU control
  input  logic                     cpu_bp_i,
  output logic                     cpu_stall_o,
  output logic                     cpu_rst_o
);

  logic             biu_strobe;
  logic             biu_rd;
  logic             biu_rdy;
  dbg_pkg::word_t   biu_addr;
  dbg_pkg::word_t   biu_wdata;
  dbg_pkg::word_t   biu_rdata;
  logic             crc_clr;
  logic             crc_en;
  logic             crc_shift;
  logic             crc_bit;
  logic             crc_serial;
  dbg_pkg::word_t   crc_value;
  logic             status_we;
  dbg_pkg::status_t status_wdata;
  dbg_pkg::status_t status_value;

  ////////////////////////////////////////
  // Controller and its helpers
  ////////////////////////////////////////

  dbg_burst_ctrl i_dbg_burst_ctrl (
    .tck_i           (tck_i),
    .rst_i           (rst_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .module_tdo_o    (module_tdo_o),
    .top_inhibit_o   (top_inhibit_o),
    .biu_strobe_o    (biu_strobe),
    .biu_rd_o        (biu_rd),
    .biu_addr_o      (biu_addr),
    .biu_wdata_o     (biu_wdata),
    .biu_rdy_i       (biu_rdy),
    .biu_rdata_i     (biu_rdata),
    .crc_clr_o       (crc_clr),
    .crc_en_o        (crc_en),
    .crc_shift_o     (crc_shift),
    .crc_bit_o       (crc_bit),
    .crc_value_i     (crc_value),
    .crc_serial_i    (crc_serial),
    .status_we_o     (status_we),
    .status_wdata_o  (status_wdata),
    .status_value_i  (status_value)
  );

  dbg_spr_biu i_dbg_spr_biu (
    .tck_i      (tck_i),
    .rst_i      (rst_i),
    .strobe_i   (biu_strobe),
    .rd_i       (biu_rd),
    .addr_i     (biu_addr),
    .wdata_i    (biu_wdata),
    .rdy_o      (biu_rdy),
    .rdata_o    (biu_rdata),
    .cpu_addr_o (cpu_addr_o),
    .cpu_data_o (cpu_data_o),
    .cpu_data_i (cpu_data_i),
    .cpu_stb_o  (cpu_stb_o),
    .cpu_we_o   (cpu_we_o),
    .cpu_ack_i  (cpu_ack_i)
  );

  dbg_crc32 i_dbg_crc32 (
    .tck_i    (tck_i),
    .rst_i    (rst_i),
    .clr_i    (crc_clr),
    .en_i     (crc_en),
    .shift_i  (crc_shift),
    .bit_i    (crc_bit),
    .crc_o    (crc_value),
    .serial_o (crc_serial)
  );

  // Stall and reset lines to the CPU
  dbg_status_reg i_dbg_status_reg (
    .tck_i       (tck_i),
    .rst_i       (rst_i),
    .we_i        (status_we),
    .wdata_i     (status_wdata),
    .bp_i        (cpu_bp_i),
    .status_o    (status_value),
    .cpu_stall_o (cpu_stall_o),
    .cpu_rst_o   (cpu_rst_o)
  );

endmodule

// File: verilog/dbg_burst_ctrl.sv
`timescale 1ns/10ps
`include "dbg_macros.svh"

module dbg_burst_ctrl (
  input  logic                     tck_i,
  input  logic                     rst_i,
  // TAP
  input  logic                     capture_dr_i,
  input  logic                     shift_dr_i,
  input  logic                     update_dr_i,
  input  logic                     module_select_i,
  input  logic                     tdi_i,
  input  logic [`DBG_DR_WIDTH-1:0] data_register_i,
  output logic                     module_tdo_o,
  output logic                     top_inhibit_o,
  // Bus unit
  output logic                     biu_strobe_o,
  output logic                     biu_rd_o,
  output dbg_pkg::word_t           biu_addr_o,
  output dbg_pkg::word_t           biu_wdata_o,
  input  logic                     biu_rdy_i,
  input  dbg_pkg::word_t           biu_rdata_i,
  // CRC
  output logic                     crc_clr_o,
  output logic                     crc_en_o,
  output logic                     crc_shift_o,
  output logic                     crc_bit_o,
  input  dbg_pkg::word_t           crc_value_i,
  input  logic                     crc_serial_i,
  // Status register
  output logic                     status_we_o,
  output dbg_pkg::status_t         status_wdata_o,
  input  dbg_pkg::status_t         status_value_i
);

  localparam dbg_pkg::bitcnt_t LAST_BIT = 6'd31;  // Last bit of a data word
  localparam dbg_pkg::bitcnt_t CRC_BITS = 6'd32;

  // TDO sources
  localparam logic [1:0] TDO_RDY   = 2'd0;
  localparam logic [1:0] TDO_SHIFT = 2'd1;
  localparam logic [1:0] TDO_MATCH = 2'd2;
  localparam logic [1:0] TDO_CRC   = 2'd3;

  dbg_pkg::burst_state_t state, state_nxt;
  dbg_pkg::word_t        addr_q;    // Address of the next SPR access
  dbg_pkg::opcode_t      op_q;      // Latched burst opcode
  dbg_pkg::count_t       word_cnt;  // Words still to move
  dbg_pkg::bitcnt_t      bit_cnt;
  dbg_pkg::word_t        out_sr;    // Read data or status toward TDO
  dbg_pkg::opcode_t      op_in;

  logic       cmd_hit;      // Update of a command addressed to us
  logic       burst_cmd;
  logic       last_bit;
  logic       word_zero;
  logic       more_words;   // Another read still to start after this word
  logic       crc_match;
  logic       cmd_ld;
  logic       addr_inc;
  logic       word_dec;
  logic       bit_rst;
  logic       bit_en;
  logic       out_ld;
  logic       out_shift;
  logic       out_src_biu;  // Load source, bus data or status
  logic       rd_next;      // Read word boundary
  logic       crc_from_tdi;
  logic [1:0] tdo_sel;

  // Decode straight from the data register
  assign op_in     = data_register_i[`DBG_OP_HI:`DBG_OP_LO];
  assign cmd_hit   = module_select_i & update_dr_i & ~data_register_i[`DBG_TOP_BIT];
  assign burst_cmd = (op_in == `DBG_CMD_BWRITE32) | (op_in == `DBG_CMD_BREAD32);

  assign status_we_o    = (state == dbg_pkg::IDLE) && cmd_hit && (op_in == `DBG_CMD_IREG_WR);
  assign status_wdata_o = data_register_i[`DBG_SREG_HI:`DBG_SREG_LO];

  assign last_bit   = (bit_cnt == LAST_BIT);
  assign word_zero  = (word_cnt == 16'd0);
  assign more_words = (word_cnt > 16'd1);
  assign crc_match  = (data_register_i[`DBG_TOP_BIT -: 32] == crc_value_i);

  assign biu_rd_o    = (op_q == `DBG_CMD_BREAD32);
  assign biu_addr_o  = addr_q;
  assign biu_wdata_o = {tdi_i, data_register_i[`DBG_TOP_BIT -: 31]};  // TDI is one bit ahead
  assign crc_bit_o   = crc_from_tdi ? tdi_i : out_sr[0];

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      state <= dbg_pkg::IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt     = state;
    cmd_ld        = 1'b0;
    addr_inc      = 1'b0;
    word_dec      = 1'b0;
    bit_rst       = 1'b0;
    bit_en        = 1'b0;
    out_ld        = 1'b0;
    out_shift     = 1'b0;
    out_src_biu   = 1'b1;
    rd_next       = 1'b0;
    tdo_sel       = TDO_SHIFT;
    biu_strobe_o  = 1'b0;
    crc_clr_o     = 1'b0;
    crc_en_o      = 1'b0;
    crc_shift_o   = 1'b0;
    crc_from_tdi  = 1'b0;
    top_inhibit_o = 1'b0;

    case (state)
      dbg_pkg::IDLE: begin
        out_src_biu = 1'b0;  // Status read-back
        out_ld      = module_select_i & capture_dr_i;
        out_shift   = module_select_i & shift_dr_i;
        if (cmd_hit && burst_cmd) begin
          cmd_ld    = 1'b1;
          bit_rst   = 1'b1;
          crc_clr_o = 1'b1;
          state_nxt = (op_in == `DBG_CMD_BREAD32) ? dbg_pkg::RBEGIN : dbg_pkg::WREADY;
        end
      end
      dbg_pkg::RBEGIN: begin
        if (word_zero) begin
          state_nxt = dbg_pkg::IDLE;  // Empty burst
        end else begin
          biu_strobe_o = 1'b1;  // First read runs while the host recaptures
          addr_inc     = 1'b1;
          state_nxt    = dbg_pkg::RREADY;
        end
      end
      dbg_pkg::RREADY: begin
        if (module_select_i && capture_dr_i) state_nxt = dbg_pkg::RSTATUS;
      end
      dbg_pkg::RSTATUS: begin
        tdo_sel       = TDO_RDY;  // Host start bit
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (biu_rdy_i) begin
          rd_next   = 1'b1;
          state_nxt = dbg_pkg::RBURST;
        end
      end
      dbg_pkg::RBURST: begin
        out_shift     = 1'b1;
        bit_en        = 1'b1;
        crc_en_o      = 1'b1;  // CRC over the bits leaving on TDO
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (last_bit) begin
          if (word_zero) state_nxt = dbg_pkg::RCRC;
          else           rd_next   = 1'b1;
        end
      end
      dbg_pkg::RCRC: begin
        tdo_sel       = TDO_CRC;
        crc_shift_o   = 1'b1;  // Runs until update, no count needed
        top_inhibit_o = 1'b1;
        if (update_dr_i) state_nxt = dbg_pkg::IDLE;
      end
      dbg_pkg::WREADY: begin
        if (word_zero) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (module_select_i && capture_dr_i) begin
          state_nxt = dbg_pkg::WWAIT;
        end
      end
      dbg_pkg::WWAIT: begin
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (module_select_i && data_register_i[`DBG_TOP_BIT]) begin
          // Start bit is in the DR, first data bit is on TDI now
          bit_en       = 1'b1;
          word_dec     = 1'b1;
          crc_en_o     = 1'b1;
          crc_from_tdi = 1'b1;
          state_nxt    = dbg_pkg::WBURST;
        end
      end
      dbg_pkg::WBURST: begin
        bit_en        = 1'b1;
        crc_en_o      = 1'b1;
        crc_from_tdi  = 1'b1;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (last_bit) begin
          bit_rst      = 1'b1;
          biu_strobe_o = 1'b1;  // Word complete with this TDI bit
          addr_inc     = 1'b1;
          word_dec     = 1'b1;
          if (word_zero) state_nxt = dbg_pkg::WCRC;
        end
      end
      dbg_pkg::WCRC: begin
        bit_en        = 1'b1;
        top_inhibit_o = 1'b1;
        if (update_dr_i) begin
          state_nxt = dbg_pkg::IDLE;
        end else if (bit_cnt == CRC_BITS) begin
          tdo_sel   = TDO_MATCH;  // Host CRC now sits in DR[52:21]
          state_nxt = dbg_pkg::WMATCH;
        end
      end
      dbg_pkg::WMATCH: begin
        tdo_sel       = TDO_MATCH;
        top_inhibit_o = 1'b1;
        if (update_dr_i) state_nxt = dbg_pkg::IDLE;
      end
      default: state_nxt = dbg_pkg::IDLE;
    endcase

    // Load the fetched word and start the next read
    if (rd_next) begin
      out_ld   = 1'b1;
      bit_rst  = 1'b1;
      word_dec = 1'b1;
      if (more_words) begin
        biu_strobe_o = 1'b1;
        addr_inc     = 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Counters and output shifter
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      addr_q   <= '0;
      op_q     <= '0;
      word_cnt <= '0;
      bit_cnt  <= '0;
      out_sr   <= '0;
    end else begin
      if (cmd_ld) begin
        addr_q   <= data_register_i[`DBG_ADDR_HI:`DBG_ADDR_LO];
        op_q     <= op_in;
        word_cnt <= data_register_i[`DBG_CNT_HI:`DBG_CNT_LO];
      end else begin
        if (addr_inc) addr_q <= addr_q + 32'd1;  // SPRs are word addressed
        if (word_dec) word_cnt <= word_cnt - 16'd1;
      end
      if (bit_rst)     bit_cnt <= '0;
      else if (bit_en) bit_cnt <= bit_cnt + 6'd1;
      if (out_ld)         out_sr <= out_src_biu ? biu_rdata_i : dbg_pkg::word_t'(status_value_i);
      else if (out_shift) out_sr <= {1'b0, out_sr[31:1]};
    end
  end

  always_comb begin
    case (tdo_sel)
      TDO_RDY:   module_tdo_o = biu_rdy_i;
      TDO_MATCH: module_tdo_o = crc_match;
      TDO_CRC:   module_tdo_o = crc_serial_i;
      default:   module_tdo_o = out_sr[0];
    endcase
  end

  a_state_legal : assert property (@(posedge tck_i) disable iff (rst_i)
    state inside {dbg_pkg::IDLE, dbg_pkg::RBEGIN, dbg_pkg::RREADY, dbg_pkg::RSTATUS,
                  dbg_pkg::RBURST, dbg_pkg::RCRC, dbg_pkg::WREADY, dbg_pkg::WWAIT,
                  dbg_pkg::WBURST, dbg_pkg::WCRC, dbg_pkg::WMATCH});

endmodule

// File: verilog/dbg_spr_biu.sv
`timescale 1ns/10ps

module dbg_spr_biu (
  input  logic           tck_i,
  input  logic           rst_i,
  // Request side
  input  logic           strobe_i,  // One cycle long and only while rdy_o
  input  logic           rd_i,      // 1 read, 0 write
  input  dbg_pkg::word_t addr_i,
  input  dbg_pkg::word_t wdata_i,
  output logic           rdy_o,
  output dbg_pkg::word_t rdata_o,
  // SPR bus
  output dbg_pkg::word_t cpu_addr_o,
  output dbg_pkg::word_t cpu_data_o,
  input  dbg_pkg::word_t cpu_data_i,
  output logic           cpu_stb_o,
  output logic           cpu_we_o,
  input  logic           cpu_ack_i
);

  logic           stb_q;
  logic           we_q;
  logic           rdy_q;
  logic           start;  // Request accepted this cycle
  logic           done;   // Bus acked this cycle
  dbg_pkg::word_t addr_q;
  dbg_pkg::word_t wdata_q;
  dbg_pkg::word_t rdata_q;

  assign start = strobe_i & rdy_q;
  assign done  = stb_q & cpu_ack_i;

  // Ready drops after the strobe and returns the cycle after ack
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
      we_q  <= 1'b0;
      rdy_q <= 1'b1;
    end else if (start) begin
      stb_q <= 1'b1;
      we_q  <= ~rd_i;
      rdy_q <= 1'b0;
    end else if (done) begin
      stb_q <= 1'b0;
      we_q  <= 1'b0;
      rdy_q <= 1'b1;
    end
  end

  // Request held on the bus until ack
  always_ff @(posedge tck_i) begin
    if (start) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
    end
    if (done && !we_q) begin
      rdata_q <= cpu_data_i;  // Valid once rdy_o is back
    end
  end

  assign rdy_o      = rdy_q;
  assign rdata_o    = rdata_q;
  assign cpu_stb_o  = stb_q;
  assign cpu_we_o   = we_q;
  assign cpu_addr_o = addr_q;
  assign cpu_data_o = wdata_q;

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Controller keeps to the back-pressure rule
  a_no_strobe_busy : assert property (@(posedge tck_i) disable iff (rst_i)
    strobe_i |-> rdy_o);

endmodule

// File: verilog/dbg_status_reg.sv
`timescale 1ns/10ps

module dbg_status_reg (
  input  logic             tck_i,
  input  logic             rst_i,
  input  logic             we_i,      // Status write from the TAP
  input  dbg_pkg::status_t wdata_i,
  input  logic             bp_i,      // CPU breakpoint hit
  output dbg_pkg::status_t status_o,
  output logic             cpu_stall_o,
  output logic             cpu_rst_o
);

  dbg_pkg::status_t status_q;

  // Write loads both bits
  // A breakpoint stalls the CPU unless a write lands in the same cycle
  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      status_q <= '0;
    end else if (we_i) begin
      status_q <= wdata_i;
    end else if (bp_i) begin
      status_q[0] <= 1'b1;  // Stall
    end
  end

  assign status_o    = status_q;     // Read back through the output shift register
  assign cpu_stall_o = status_q[0];
  assign cpu_rst_o   = status_q[1];

endmodule

// File: verilog/dbg_crc32.sv
`timescale 1ns/10ps
`include "dbg_macros.svh"

module dbg_crc32 (
  input  logic           tck_i,
  input  logic           rst_i,
  input  logic           clr_i,    // Restart, wins over the rest
  input  logic           en_i,     // Fold bit_i into the CRC
  input  logic           shift_i,  // Plain shift, used to send the result out
  input  logic           bit_i,
  output dbg_pkg::word_t crc_o,
  output logic           serial_o
);

  dbg_pkg::word_t crc_q;
  logic           fb;  // Old LSB against the incoming bit

  assign fb = crc_q[0] ^ bit_i;

  ////////////////////////////////////////
  // LSB-first CRC-32, one bit per clock
  ////////////////////////////////////////

  always_ff @(posedge tck_i or posedge rst_i) begin
    if (rst_i) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (clr_i) begin
      crc_q <= `DBG_CRC_INIT;
    end else if (en_i) begin
      crc_q <= {1'b0, crc_q[31:1]} ^ (fb ? `DBG_CRC_POLY : 32'h0);
    end else if (shift_i) begin
      // Same register doubles as the output shifter
      crc_q <= {1'b0, crc_q[31:1]};
    end
  end

  assign crc_o    = crc_q;
  assign serial_o = crc_q[0];  // Next CRC bit for TDO

endmodule

// File: verilog/dbg_pkg.sv
package dbg_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] word_t;    // SPR address and data
  typedef logic [15:0] count_t;   // Words left in a burst
  typedef logic [3:0]  opcode_t;  // Command opcode
  typedef logic [5:0]  bitcnt_t;  // Bit position, needs to reach 32 for the CRC
  typedef logic [1:0]  status_t;  // [0] stall, [1] reset

  // Burst FSM
  // R* states run a burst read, W* states a burst write
  typedef enum logic [3:0] {
    IDLE,     // Status access and command decode
    RBEGIN,   // Strobe the first read
    RREADY,   // Wait for capture
    RSTATUS,  // Ready bit on TDO until the bus unit has data
    RBURST,   // Data words out
    RCRC,     // CRC out until update
    WREADY,   // Wait for capture
    WWAIT,    // Wait for the start bit
    WBURST,   // Data words in
    WCRC,     // Host CRC in
    WMATCH    // Match bit out until update
  } burst_state_t;

endpackage

// File: verilog/dbg_macros.svh
`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

////////////////////////////////////////
// Data register layout
////////////////////////////////////////

`define DBG_DR_WIDTH 53   // Bits shifted per DR scan
`define DBG_TOP_BIT  52   // Low when the command is for this module

// Opcode field
`define DBG_OP_HI    51
`define DBG_OP_LO    48

// Burst start address and word count
`define DBG_ADDR_HI  47
`define DBG_ADDR_LO  16
`define DBG_CNT_HI   15
`define DBG_CNT_LO   0

// Status write data, {reset, stall}
`define DBG_SREG_HI  47
`define DBG_SREG_LO  46

////////////////////////////////////////
// Commands and CRC
////////////////////////////////////////

`define DBG_CMD_BWRITE32 4'h3
`define DBG_CMD_BREAD32  4'h7
`define DBG_CMD_IREG_WR  4'h9

`define DBG_CRC_POLY 32'hEDB8_8320  // Reflected CRC-32
`define DBG_CRC_INIT 32'hFFFF_FFFF

`endif
